/* vlog.f */
+incdir+source
source/rhythm_pkg.sv
source/step_timer.sv
source/note_judge.sv
source/playfield_output.sv
source/rhythm_top.sv
testbench/rhythm_chk.sv
testbench/rhythm_tb.sv

/* testbench/rhythm_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rhythm_params.svh"

module rhythm_tb;

    localparam int STEP_CYCLES = 4;
    localparam int WAIT_LIMIT  = 200;

    // GOOD GAME banner with column 15 first
    localparam logic [`RT_FRAME_W-1:0] BANNER = {
        16'h7E54, 16'h0A7C, 16'h0E00, 16'h0078,
        16'h3C40, 16'h2420, 16'h3C40, 16'h0078,
        16'h0000, 16'h3C7C, 16'h2448, 16'h3C78,
        16'h0000, 16'h7E7E, 16'h5252, 16'h7676
    };

    logic                           clk;
    logic                           rst_n;
    logic [`RT_PERIOD_W-1:0]        step_period;
    logic                           pause;
    rhythm_pkg::lane_row_t          key_hit;
    rhythm_pkg::lane_row_t          chart_row;
    wire [`RT_ADDR_W-1:0]           chart_addr;
    wire [6:0]                      score;
    wire [`RT_FRAME_W-1:0]          frame_flat;
    wire rhythm_pkg::host_status_t  status;
    wire                            status_valid;
    wire rhythm_pkg::verdict_t      verdict;

    rhythm_pkg::lane_row_t  chart_mem [0:(1 << `RT_ADDR_W)-1];
    rhythm_pkg::field_t     model;       // expected field
    logic [`RT_ADDR_W-1:0]  last_addr;
    logic                   autoplay;    // press whatever sits on the bottom row

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     test_errors;
    int     misses_seen;
    bit     timed_out;
    string  test_name;

    rhythm_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .step_period  (step_period),
        .pause        (pause),
        .key_hit      (key_hit),
        .chart_row    (chart_row),
        .chart_addr   (chart_addr),
        .score        (score),
        .frame_flat   (frame_flat),
        .status       (status),
        .status_valid (status_valid),
        .verdict      (verdict)
    );

    always #20 clk = ~clk;

    task automatic compare_value(input string what, input logic [`RT_FRAME_W-1:0] exp_v,
                                 input logic [`RT_FRAME_W-1:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("MISMATCH %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
        end
    endtask

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        $display("TIMEOUT in %s: no %s within %0d cycles", test_name, what, WAIT_LIMIT);
    endtask

    // follow the field at each falling edge and then drive chart and keys
    task automatic tick();
        @(negedge clk);
        if (chart_addr !== last_addr) begin
            model     = {model[`RT_ROWS-2:0], chart_mem[last_addr]};
            last_addr = chart_addr;
        end
        if (verdict == rhythm_pkg::V_MISS) begin
            misses_seen++;
        end
        chart_row = chart_mem[chart_addr];
        key_hit   = autoplay ? model[`RT_ROWS-1] : '0;
    endtask

    task automatic wait_step(output int n);
        logic [`RT_ADDR_W-1:0] start;
        start = chart_addr;
        n = 0;
        while (chart_addr === start && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (chart_addr === start) begin
            note_timeout("chart address change");
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
        tests++;
    endtask

    task automatic finish_test();
        $display("test %-18s done, %0d errors", test_name, errors - test_errors);
    endtask

    // three lit columns per lane with row 0 at the word msb
    function automatic logic [`RT_FRAME_W-1:0] render(input rhythm_pkg::field_t f);
        logic [`RT_FRAME_W-1:0] img;
        int c;
        int r;
        img = '0;
        for (c = 0; c < 16; c++) begin
            if (c % 4 != 3) begin
                for (r = 0; r < `RT_ROWS; r++) begin
                    img[16*c + 15 - r] = f[r][c / 4];
                end
            end
        end
        return img;
    endfunction

    function automatic rhythm_pkg::lane_row_t bottom_of(input logic [`RT_FRAME_W-1:0] img);
        rhythm_pkg::lane_row_t row;
        int lane;
        for (lane = 0; lane < `RT_LANES; lane++) begin
            row[lane] = img[16*4*lane];   // bottom row is the word lsb
        end
        return row;
    endfunction

    // expected host byte built msb first
    function automatic logic [7:0] status_byte(input logic over, input logic paused,
                                               input logic idle);
        return {2'b11, over, paused, 2'b00, idle, 1'b1};
    endfunction

    initial begin
        int                     n;
        int                     a;
        int                     lane;
        int                     pulses;
        int                     miss_base;
        logic [31:0]            rnd;
        logic [`RT_ADDR_W-1:0]  addr_snap;
        logic [6:0]             score_snap;
        logic [`RT_FRAME_W-1:0] frame_snap;
        rhythm_pkg::lane_row_t  first_row;

        clk         = 1'b0;
        rst_n       = 1'b0;
        step_period = STEP_CYCLES;
        pause       = 1'b0;
        key_hit     = '0;
        chart_row   = '0;
        model       = '0;
        last_addr   = '0;
        autoplay    = 1'b1;
        seed        = 32'ha78d_9c78;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        misses_seen = 0;
        timed_out   = 1'b0;
        test_name   = "setup";
        for (a = 0; a < (1 << `RT_ADDR_W); a++) begin
            rnd          = $random(seed);
            chart_mem[a] = rnd[`RT_LANES-1:0];
        end

        repeat (4) tick();
        rst_n = 1'b1;

        start_test("reset");
        tick();
        compare_value("score", 0, score);
        compare_value("chart_addr", 0, chart_addr);
        compare_value("frame_flat", 0, frame_flat);
        compare_value("status_valid", 0, status_valid);
        finish_test();

        start_test("step timing");
        wait_step(n);
        repeat (6) begin
            addr_snap = chart_addr;
            wait_step(n);
            compare_value("cycles per step", STEP_CYCLES, n);
            compare_value("chart_addr", addr_snap + 1'b1, chart_addr);
        end
        finish_test();

        start_test("falling notes");
        a = 0;
        wait_step(n);
        while (model[0] == '0 && a < WAIT_LIMIT / STEP_CYCLES) begin
            wait_step(n);
            a++;
        end
        if (model[0] == '0) begin
            note_timeout("nonzero chart row");
        end
        first_row = model[0];
        repeat (`RT_ROWS - 1) begin
            wait_step(n);
            tick();   // frame trails the field by a cycle
            compare_value("frame_flat", render(model), frame_flat);
            for (lane = 0; lane < `RT_LANES; lane++) begin
                compare_value("spacer column", 0, frame_flat[16*(4*lane + 3) +: 16]);
            end
        end
        compare_value("bottom row on frame", first_row, bottom_of(frame_flat));
        finish_test();

        start_test("hits and score");
        miss_base = misses_seen;
        repeat (4) begin
            n = 0;
            while (verdict !== rhythm_pkg::V_HIT && n < WAIT_LIMIT) begin
                tick();
                n++;
            end
            if (verdict !== rhythm_pkg::V_HIT) begin
                note_timeout("hit step");
            end
            compare_value("status", status_byte(1'b0, 1'b0, 1'b0), status);
            score_snap = score;
            wait_step(n);
            compare_value("score", score_snap + 1'b1, score);
            compare_value("miss count", miss_base, misses_seen);
        end
        finish_test();

        start_test("pause and status");
        wait_step(n);
        autoplay = 1'b0;
        key_hit  = '0;
        tick();
        pause = 1'b1;
        tick();
        addr_snap  = chart_addr;
        score_snap = score;
        frame_snap = frame_flat;
        pulses     = 0;
        repeat (12) begin
            tick();
            if (status_valid) begin
                pulses++;
            end
            compare_value("chart_addr", addr_snap, chart_addr);
            compare_value("score", score_snap, score);
            compare_value("frame_flat", frame_snap, frame_flat);
        end
        compare_value("status_valid pulses", 1, pulses);
        compare_value("status", status_byte(1'b0, 1'b1, 1'b1), status);
        pause = 1'b0;
        finish_test();

        start_test("game over");
        score_snap = score;
        n = 0;
        while (!status.over && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (!status.over) begin
            note_timeout("game over");
        end
        compare_value("status", status_byte(1'b1, 1'b0, 1'b1), status);
        compare_value("miss count", `RT_MISS_LIMIT, misses_seen);
        compare_value("score", score_snap, score);
        tick();
        compare_value("frame_flat", BANNER, frame_flat);
        addr_snap = chart_addr;
        repeat (8) begin
            tick();
            compare_value("chart_addr", addr_snap, chart_addr);
            compare_value("score", score_snap, score);
            compare_value("frame_flat", BANNER, frame_flat);
        end
        finish_test();

        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures, timeout %0d",
                 tests, checks, errors, dut.chk.fail_cnt, timed_out);
        if (errors == 0 && dut.chk.fail_cnt == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/rhythm_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rhythm_params.svh"

module rhythm_chk (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire [`RT_PERIOD_W-1:0]        step_period,
    input  wire                           pause,
    input  wire                           step,
    input  wire rhythm_pkg::phase_t       phase,
    input  wire [`RT_ADDR_W-1:0]          chart_addr,
    input  wire [6:0]                     score,
    input  wire rhythm_pkg::host_status_t status,
    input  wire                           status_valid,
    input  wire rhythm_pkg::verdict_t     verdict
);

    int fail_cnt = 0;

    logic [`RT_ADDR_W-1:0]  addr_q;
    logic [`RT_PERIOD_W:0]  gap;     // cycles since the last address change
    logic                   clean;   // no pause or game over inside the gap

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
            gap    <= '0;
            clean  <= 1'b0;
        end else begin
            addr_q <= chart_addr;
            if (chart_addr != addr_q) begin
                gap   <= 1;
                clean <= !pause && (phase == rhythm_pkg::PH_PLAY);
            end else begin
                if (gap != '1) begin
                    gap <= gap + 1'b1;
                end
                if (pause || phase == rhythm_pkg::PH_OVER) begin
                    clean <= 1'b0;
                end
            end
        end
    end

    a_step_gap: assert property (@(posedge clk) disable iff (!rst_n)
        (chart_addr != addr_q) && clean |-> gap == step_period)
        else begin fail_cnt++; $error("chart address advanced off the step period"); end

    a_addr_inc: assert property (@(posedge clk) disable iff (!rst_n)
        (chart_addr != $past(chart_addr)) |->
            chart_addr == `RT_ADDR_W'($past(chart_addr) + 1))
        else begin fail_cnt++; $error("chart address moved by more than one"); end

    a_step_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        step |=> !step)
        else begin fail_cnt++; $error("step strobe wider than one cycle"); end

    a_score_rise: assert property (@(posedge clk) disable iff (!rst_n)
        score >= $past(score) && score <= `RT_SCORE_MAX)
        else begin fail_cnt++; $error("score fell or went past its limit"); end

    // saturating increment on a hit step
    a_hit_score: assert property (@(posedge clk) disable iff (!rst_n)
        verdict == rhythm_pkg::V_HIT |=>
            score == (($past(score) == `RT_SCORE_MAX) ? $past(score) : $past(score) + 1))
        else begin fail_cnt++; $error("hit step did not add one to the score"); end

    a_over_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        phase == rhythm_pkg::PH_OVER |=>
            $stable(score) && $stable(chart_addr) && phase == rhythm_pkg::PH_OVER)
        else begin fail_cnt++; $error("game moved on after game over"); end

    a_pause_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        pause |=> $stable(chart_addr) && $stable(score))
        else begin fail_cnt++; $error("game moved on while paused"); end

    a_status_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        status_valid == (status != $past(status)))
        else begin fail_cnt++; $error("status strobe out of line with a status change"); end

endmodule

bind rhythm_top rhythm_chk chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .step_period  (step_period),
    .pause        (pause),
    .step         (step),
    .phase        (phase),
    .chart_addr   (chart_addr),
    .score        (score),
    .status       (status),
    .status_valid (status_valid),
    .verdict      (verdict)
);

`default_nettype wire

/* source/rhythm_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rhythm_params.svh"

module rhythm_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire [`RT_PERIOD_W-1:0]        step_period,
    input  wire                           pause,
    input  wire rhythm_pkg::lane_row_t    key_hit,
    input  wire rhythm_pkg::lane_row_t    chart_row,
    output wire [`RT_ADDR_W-1:0]          chart_addr,
    output wire [6:0]                     score,
    output wire [`RT_FRAME_W-1:0]         frame_flat,
    output wire rhythm_pkg::host_status_t status,
    output wire                           status_valid,
    output wire rhythm_pkg::verdict_t     verdict
);

    wire                            step;
    wire rhythm_pkg::field_t        field;
    wire rhythm_pkg::phase_t        phase;
    wire                            paused;
    wire rhythm_pkg::lane_row_t     hit_now;

    // note speed
    step_timer u_step_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .step_period (step_period),
        .step        (step)
    );

    note_judge u_note_judge (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (step),
        .pause      (pause),
        .key_hit    (key_hit),
        .chart_row  (chart_row),
        .field      (field),
        .phase      (phase),
        .paused     (paused),
        .hit_now    (hit_now),
        .score      (score),
        .chart_addr (chart_addr),
        .verdict    (verdict)
    );

    // LED frame and host byte
    playfield_output u_playfield_output (
        .clk          (clk),
        .rst_n        (rst_n),
        .field        (field),
        .phase        (phase),
        .paused       (paused),
        .hit_now      (hit_now),
        .frame_flat   (frame_flat),
        .status       (status),
        .status_valid (status_valid)
    );

endmodule

`default_nettype wire

/* source/playfield_output.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rhythm_params.svh"

module playfield_output (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire rhythm_pkg::field_t       field,
    input  wire rhythm_pkg::phase_t       phase,
    input  wire                           paused,
    input  wire rhythm_pkg::lane_row_t    hit_now,
    output logic [`RT_FRAME_W-1:0]        frame_flat,
    output rhythm_pkg::host_status_t      status,
    output logic                          status_valid
);

    localparam int COLS       = `RT_FRAME_W / `RT_ROWS;
    localparam int LANE_PITCH = COLS / `RT_LANES;   // lit columns plus a spacer
    localparam int LIT_COLS   = LANE_PITCH - 1;

    // GOOD GAME, column 15 first, row 0 at each word msb
    localparam logic [`RT_FRAME_W-1:0] BANNER = {
        16'h7E54, 16'h0A7C, 16'h0E00, 16'h0078,
        16'h3C40, 16'h2420, 16'h3C40, 16'h0078,
        16'h0000, 16'h3C7C, 16'h2448, 16'h3C78,
        16'h0000, 16'h7E7E, 16'h5252, 16'h7676
    };

    // idle value, so no strobe right after reset
    localparam rhythm_pkg::host_status_t STATUS_RST = '{
        top_ones: 2'b11,
        over:     1'b0,
        paused:   1'b0,
        spare:    2'b00,
        idle_now: 1'b1,
        link:     1'b1
    };

    logic [`RT_FRAME_W-1:0]     frame_next;
    rhythm_pkg::host_status_t   status_next;

    // each lane drawn LIT_COLS wide, spacer columns stay dark
    always_comb begin
        frame_next = '0;
        for (int lane = 0; lane < `RT_LANES; lane++) begin
            for (int k = 0; k < LIT_COLS; k++) begin
                for (int r = 0; r < `RT_ROWS; r++) begin
                    frame_next[(LANE_PITCH*lane + k)*`RT_ROWS + (`RT_ROWS-1-r)] =
                        field[r][lane];
                end
            end
        end
    end

    always_comb begin
        status_next.top_ones = 2'b11;
        status_next.over     = (phase == rhythm_pkg::PH_OVER);
        status_next.paused   = paused;
        status_next.spare    = 2'b00;
        status_next.idle_now = ~|hit_now;
        status_next.link     = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_flat   <= '0;
            status       <= STATUS_RST;
            status_valid <= 1'b0;
        end else begin
            // one cycle behind the field
            if (phase == rhythm_pkg::PH_OVER) begin
                frame_flat <= BANNER;
            end else begin
                frame_flat <= frame_next;
            end

            status       <= status_next;
            status_valid <= (status_next != status);  // lines up with the new byte
        end
    end

endmodule

`default_nettype wire

/* source/note_judge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rhythm_params.svh"

module note_judge (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           step,
    input  wire                           pause,
    input  wire rhythm_pkg::lane_row_t    key_hit,
    input  wire rhythm_pkg::lane_row_t    chart_row,
    output rhythm_pkg::field_t            field,
    output rhythm_pkg::phase_t            phase,
    output logic                          paused,
    output rhythm_pkg::lane_row_t         hit_now,
    output logic [6:0]                    score,
    output logic [`RT_ADDR_W-1:0]         chart_addr,
    output rhythm_pkg::verdict_t          verdict
);

    localparam int MISS_W = $clog2(`RT_MISS_LIMIT + 1);
    localparam logic [6:0] SCORE_MAX = 7'(`RT_SCORE_MAX);
    localparam logic [MISS_W-1:0] MISS_LIMIT = MISS_W'(`RT_MISS_LIMIT);

    logic [MISS_W-1:0]      miss_cnt;
    logic [MISS_W-1:0]      miss_cnt_inc;
    logic                   advance;
    logic                   game_end;
    rhythm_pkg::lane_row_t  missed;

    // judge row is the bottom one
    assign hit_now = key_hit & field[`RT_ROWS-1];
    assign missed  = field[`RT_ROWS-1] & ~key_hit;

    assign advance = step && (phase == rhythm_pkg::PH_PLAY) && !pause;

    assign miss_cnt_inc = miss_cnt + 1'b1;

    // a miss step that completes the miss budget
    assign game_end = (verdict == rhythm_pkg::V_MISS) && (miss_cnt_inc == MISS_LIMIT);

    // a miss outranks a hit in the same step
    always_comb begin
        verdict = rhythm_pkg::V_IDLE;
        if (advance) begin
            if (|missed) begin
                verdict = rhythm_pkg::V_MISS;
            end else if (|hit_now) begin
                verdict = rhythm_pkg::V_HIT;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            field      <= '0;
            phase      <= rhythm_pkg::PH_PLAY;
            paused     <= 1'b0;
            score      <= '0;
            miss_cnt   <= '0;
            chart_addr <= '0;
        end else begin
            paused <= pause;

            if (advance) begin
                // hits score even on a step that also misses
                if (|hit_now && score != SCORE_MAX) begin
                    score <= score + 1'b1;
                end

                if (verdict == rhythm_pkg::V_MISS) begin
                    miss_cnt <= miss_cnt_inc;
                end

                if (game_end) begin
                    phase <= rhythm_pkg::PH_OVER;   // field freezes
                end else begin
                    // shift down, bottom row drops out with its hit notes
                    field      <= {field[`RT_ROWS-2:0], chart_row};
                    chart_addr <= chart_addr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/step_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rhythm_params.svh"

module step_timer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [`RT_PERIOD_W-1:0]  step_period,   // >= 2
    output logic                    step
);

    logic [`RT_PERIOD_W-1:0] cnt;
    logic [`RT_PERIOD_W-1:0] last;

    assign last = step_period - 1'b1;

    // one cycle out of every step_period
    assign step = (cnt == last);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt >= last) begin
            // also recovers if the period shrinks under cnt
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/rhythm_pkg.sv */
`default_nettype none

`include "rhythm_params.svh"

package rhythm_pkg;

    // bit n is lane n
    typedef logic [`RT_LANES-1:0] lane_row_t;

    // row 0 on top, row RT_ROWS-1 is the judge row
    typedef lane_row_t [`RT_ROWS-1:0] field_t;

    typedef enum logic {
        PH_PLAY = 1'b0,
        PH_OVER = 1'b1
    } phase_t;

    // outcome of one step
    typedef enum logic [1:0] {
        V_IDLE = 2'd0,
        V_HIT  = 2'd1,
        V_MISS = 2'd2
    } verdict_t;

    // host status byte, msb first
    typedef struct packed {
        logic [1:0] top_ones;   // always 2'b11
        logic       over;
        logic       paused;
        logic [1:0] spare;      // zero
        logic       idle_now;   // no key on a bottom note
        logic       link;       // live link marker
    } host_status_t;

endpackage

`default_nettype wire

/* source/rhythm_params.svh */
`ifndef RHYTHM_PARAMS_SVH
`define RHYTHM_PARAMS_SVH

// playfield geometry
`define RT_ROWS        16
`define RT_LANES       4

// 16 columns of 16 rows
`define RT_FRAME_W     256

// step period counter width
`define RT_PERIOD_W    16

// chart memory address, wraps
`define RT_ADDR_W      16

// score saturates here, fits 7 bits
`define RT_SCORE_MAX   127

// third miss ends the game
`define RT_MISS_LIMIT  3

`endif
